/* list.f */
logic/masku_pkg.sv
logic/mask_ctrl.sv
logic/mask_alu.sv
logic/mask_result_queue.sv
logic/mask_unit.sv
test/tb_mask_unit.sv

/* logic/mask_alu.sv */
`timescale 1ns/1ns

module mask_alu (
  input  masku_pkg::lane_beat_t beat_i,
  input  masku_pkg::mask_op_e   op_i,
  input  masku_pkg::vlen_t      remaining_i,
  output masku_pkg::word_t      wdata_o
);

  import masku_pkg::*;

  // Per-lane operation results, lane n at bits n*ElenW
  elen_t [NrLanes-1:0] op_res;
  // High where the bit is inside vl
  word_t               bit_en;

  // Bitwise mask logic on one lane word
  function automatic elen_t lane_logic(mask_op_e op, elen_t a, elen_t b);
    elen_t res;
    case (op)
      MOP_AND:    res = a & b;
      MOP_ANDNOT: res = a & ~b;
      MOP_OR:     res = a | b;
      MOP_XOR:    res = a ^ b;
      MOP_NAND:   res = ~(a & b);
      MOP_NOR:    res = ~(a | b);
      MOP_XNOR:   res = ~(a ^ b);
      MOP_ORNOT:  res = a | ~b;
      default:    res = '0;
    endcase
    return res;
  endfunction

  //////////////////////////////
  // Tail enable
  //////////////////////////////

  // Bits below remaining_i are live, so 256 or more enables the whole word
  always_comb begin
    for (int k = 0; k < WordW; k++) begin
      bit_en[k] = (vlen_t'(k) < remaining_i);
    end
  end

  //////////////////////////////
  // Lane datapath
  //////////////////////////////

  for (genvar l = 0; l < NrLanes; l++) begin : gen_lane
    assign op_res[l] = lane_logic(op_i,
                                  beat_i.a[l*ElenW +: ElenW],
                                  beat_i.b[l*ElenW +: ElenW]);
  end

  // Tail bits keep the old destination
  assign wdata_o = (op_res & bit_en) | (beat_i.old_vd & ~bit_en);

endmodule

/* logic/mask_ctrl.sv */
`timescale 1ns/1ns

module mask_ctrl (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Sequencer side
  input  masku_pkg::mask_req_t  req_i,
  input  logic                  req_valid_i,
  output logic                  req_ready_o,
  // Operand strobes to and from the lanes
  input  masku_pkg::lane_mask_t operand_valid_i,
  output logic                  operand_ready_o,
  // Result queue status
  input  logic                  queue_full_i,
  input  logic                  queue_pop_i,
  // Push side of the result queue
  output logic                  push_o,
  output masku_pkg::vid_t       push_id_o,
  output masku_pkg::vaddr_t     push_addr_o,
  // ALU control
  output masku_pkg::mask_op_e   op_o,
  output masku_pkg::vlen_t      issue_remaining_o,
  // Completion
  output masku_pkg::done_t      done_o
);

  import masku_pkg::*;

  typedef enum logic {
    CTRL_IDLE,
    CTRL_BUSY
  } ctrl_state_e;

  // Word index inside the destination register
  typedef logic [$clog2(WordsPerReg)-1:0] word_idx_t;

  ctrl_state_e state_d, state_q;
  mask_req_t   req_q;
  // Bits still to issue and bits still to commit
  vlen_t       issue_cnt_d, issue_cnt_q;
  vlen_t       commit_cnt_d, commit_cnt_q;
  word_idx_t   word_idx_d, word_idx_q;
  done_t       done_d, done_q;

  logic accept;
  logic consume;

  //////////////////////////////
  // Handshakes
  //////////////////////////////

  // Only one instruction in flight
  assign req_ready_o = (state_q == CTRL_IDLE);
  assign accept      = req_ready_o && req_valid_i;

  // A beat needs every lane, work left and a free queue slot
  assign consume = (state_q == CTRL_BUSY) && (&operand_valid_i) &&
                   (issue_cnt_q != '0) && !queue_full_i;

  // Same pulse acknowledges all lanes at once
  assign operand_ready_o = consume;
  assign push_o          = consume;

  // Word j of the instruction lives at vd*WordsPerReg + j
  assign push_id_o   = req_q.id;
  assign push_addr_o = vaddr_t'(req_q.vd) * vaddr_t'(WordsPerReg) + vaddr_t'(word_idx_q);

  assign op_o              = req_q.op;
  assign issue_remaining_o = issue_cnt_q;
  assign done_o            = done_q;

  //////////////////////////////
  // Counters and FSM
  //////////////////////////////

  always_comb begin
    state_d      = state_q;
    issue_cnt_d  = issue_cnt_q;
    commit_cnt_d = commit_cnt_q;
    word_idx_d   = word_idx_q;
    done_d       = '0;

    // New instruction loads both counters with vl
    if (accept) begin
      state_d      = CTRL_BUSY;
      issue_cnt_d  = req_i.vl;
      commit_cnt_d = req_i.vl;
      word_idx_d   = '0;
    end

    // Issue side, one full word per beat
    if (consume) begin
      word_idx_d = word_idx_q + 1'b1;
      if (issue_cnt_q > vlen_t'(WordW)) begin
        issue_cnt_d = issue_cnt_q - vlen_t'(WordW);
      end else begin
        issue_cnt_d = '0;
      end
    end

    // Commit side follows the queue pops
    if (queue_pop_i && (state_q == CTRL_BUSY)) begin
      if (commit_cnt_q > vlen_t'(WordW)) begin
        commit_cnt_d = commit_cnt_q - vlen_t'(WordW);
      end else begin
        commit_cnt_d = '0;
      end
      // Last word granted by every lane
      if (commit_cnt_d == '0) begin
        done_d.done[req_q.id] = 1'b1;
        state_d               = CTRL_IDLE;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= CTRL_IDLE;
      issue_cnt_q  <= '0;
      commit_cnt_q <= '0;
      word_idx_q   <= '0;
      done_q       <= '0;
    end else begin
      state_q      <= state_d;
      issue_cnt_q  <= issue_cnt_d;
      commit_cnt_q <= commit_cnt_d;
      word_idx_q   <= word_idx_d;
      done_q       <= done_d;
    end
  end

  // Instruction register, loaded on accept only
  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_q <= req_i;
    end
  end

endmodule

/* logic/mask_result_queue.sv */
`timescale 1ns/1ns

module mask_result_queue (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Push side
  input  logic                  push_i,
  input  masku_pkg::result_t    push_data_i,
  output logic                  full_o,
  // Write-back to the lanes
  output masku_pkg::lane_mask_t req_o,
  output masku_pkg::result_t    head_o,
  input  masku_pkg::lane_mask_t gnt_i,
  // Head retired by every lane
  output logic                  pop_o
);

  import masku_pkg::*;

  typedef logic [$clog2(ResultQueueDepth)-1:0] ptr_t;
  typedef logic [$clog2(ResultQueueDepth+1)-1:0] cnt_t;

  // Entry payload
  result_t    [ResultQueueDepth-1:0] data_q;
  // Lanes that still have to grant each entry
  lane_mask_t [ResultQueueDepth-1:0] pend_d, pend_q;

  ptr_t wr_ptr_d, wr_ptr_q;
  ptr_t rd_ptr_d, rd_ptr_q;
  cnt_t cnt_d, cnt_q;

  logic       empty;
  lane_mask_t head_left;

  // Wrap a pointer at the queue depth
  function automatic ptr_t ptr_next(ptr_t ptr);
    ptr_t nxt;
    if (ptr == ptr_t'(ResultQueueDepth - 1)) begin
      nxt = '0;
    end else begin
      nxt = ptr + 1'b1;
    end
    return nxt;
  endfunction

  assign empty  = (cnt_q == '0);
  assign full_o = (cnt_q == cnt_t'(ResultQueueDepth));

  //////////////////////////////
  // Head entry
  //////////////////////////////

  assign head_o = data_q[rd_ptr_q];
  assign req_o  = pend_q[rd_ptr_q];

  // Lanes still pending once this cycle's grants count
  assign head_left = pend_q[rd_ptr_q] & ~gnt_i;
  // Pop on the grant from the last outstanding lane
  assign pop_o     = !empty && (head_left == '0);

  always_comb begin
    pend_d   = pend_q;
    wr_ptr_d = wr_ptr_q;
    rd_ptr_d = rd_ptr_q;
    cnt_d    = cnt_q;

    // Granted lanes drop their request next cycle
    pend_d[rd_ptr_q] = head_left;

    if (pop_o) begin
      rd_ptr_d = ptr_next(rd_ptr_q);
    end

    // New word requests every lane
    if (push_i) begin
      pend_d[wr_ptr_q] = '1;
      wr_ptr_d         = ptr_next(wr_ptr_q);
    end

    // Push and pop together leave the count alone
    if (push_i && !pop_o) begin
      cnt_d = cnt_q + 1'b1;
    end else if (pop_o && !push_i) begin
      cnt_d = cnt_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pend_q   <= '0;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      pend_q   <= pend_d;
      wr_ptr_q <= wr_ptr_d;
      rd_ptr_q <= rd_ptr_d;
      cnt_q    <= cnt_d;
    end
  end

  // Storage, written only at the tail
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      data_q[wr_ptr_q] <= push_data_i;
    end
  end

endmodule

/* logic/mask_unit.sv */
`timescale 1ns/1ns

module mask_unit (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Sequencer
  input  masku_pkg::mask_req_t  req_i,
  input  logic                  req_valid_i,
  output logic                  req_ready_o,
  // Operands from the lanes
  input  masku_pkg::lane_beat_t operands_i,
  input  masku_pkg::lane_mask_t operand_valid_i,
  output logic                  operand_ready_o,
  // Results to the lanes
  output masku_pkg::lane_mask_t result_req_o,
  output masku_pkg::vaddr_t     result_addr_o,
  output masku_pkg::vid_t       result_id_o,
  output masku_pkg::word_t      result_wdata_o,
  input  masku_pkg::lane_mask_t result_gnt_i,
  // Completion to the sequencer
  output masku_pkg::done_t      done_o
);

  import masku_pkg::*;

  // Control to datapath
  logic     push;
  vid_t     push_id;
  vaddr_t   push_addr;
  mask_op_e op;
  vlen_t    issue_remaining;
  word_t    wdata;
  // Queue status
  logic     full;
  logic     pop;
  result_t  push_data;
  result_t  head;

  mask_ctrl i_ctrl (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .req_i             (req_i),
    .req_valid_i       (req_valid_i),
    .req_ready_o       (req_ready_o),
    .operand_valid_i   (operand_valid_i),
    .operand_ready_o   (operand_ready_o),
    .queue_full_i      (full),
    .queue_pop_i       (pop),
    .push_o            (push),
    .push_id_o         (push_id),
    .push_addr_o       (push_addr),
    .op_o              (op),
    .issue_remaining_o (issue_remaining),
    .done_o            (done_o)
  );

  mask_alu i_alu (
    .beat_i      (operands_i),
    .op_i        (op),
    .remaining_i (issue_remaining),
    .wdata_o     (wdata)
  );

  // Control fields and ALU word form one queue entry
  assign push_data = '{id: push_id, addr: push_addr, wdata: wdata};

  mask_result_queue i_queue (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .push_i      (push),
    .push_data_i (push_data),
    .full_o      (full),
    .req_o       (result_req_o),
    .head_o      (head),
    .gnt_i       (result_gnt_i),
    .pop_o       (pop)
  );

  // Head entry is common to all lanes
  assign result_addr_o  = head.addr;
  assign result_id_o    = head.id;
  assign result_wdata_o = head.wdata;

endmodule

/* logic/masku_pkg.sv */
package masku_pkg;

  //////////////////////////////
  // Sizes
  //////////////////////////////

  // Four lanes of 64 bits make one full VRF word
  localparam int unsigned NrLanes          = 4;
  localparam int unsigned ElenW            = 64;
  localparam int unsigned WordW            = NrLanes * ElenW;
  // One vector register spans eight full words
  localparam int unsigned VlenBits         = 2048;
  localparam int unsigned WordsPerReg      = VlenBits / WordW;
  // Instruction ids handed out by the sequencer
  localparam int unsigned NrVInsn          = 4;
  localparam int unsigned ResultQueueDepth = 2;

  //////////////////////////////
  // Vector types
  //////////////////////////////

  typedef logic [ElenW-1:0] elen_t;
  // Lane n holds bits n*ElenW and up
  typedef logic [WordW-1:0] word_t;
  // Wide enough to hold VlenBits itself
  typedef logic [$clog2(VlenBits):0] vlen_t;
  typedef logic [$clog2(NrVInsn)-1:0] vid_t;
  // 32 architectural vector registers
  typedef logic [4:0] vreg_t;
  // Register number on top, word index below
  typedef logic [$bits(vreg_t)+$clog2(WordsPerReg)-1:0] vaddr_t;
  typedef logic [NrLanes-1:0] lane_mask_t;

  // Mask-logical operations, a is vs2 and b is vs1
  typedef enum logic [2:0] {
    MOP_AND,
    MOP_ANDNOT,
    MOP_OR,
    MOP_XOR,
    MOP_NAND,
    MOP_NOR,
    MOP_XNOR,
    MOP_ORNOT
  } mask_op_e;

  //////////////////////////////
  // Structs
  //////////////////////////////

  // Request from the sequencer
  typedef struct packed {
    vid_t     id;
    mask_op_e op;
    vreg_t    vd;
    vlen_t    vl;
  } mask_req_t;

  // One beat of operands from all lanes
  typedef struct packed {
    word_t a;
    word_t b;
    word_t old_vd;
  } lane_beat_t;

  // One result word on its way back to the lanes
  typedef struct packed {
    vid_t   id;
    vaddr_t addr;
    word_t  wdata;
  } result_t;

  typedef struct packed {
    logic [NrVInsn-1:0] done;
  } done_t;

endpackage

/* test/tb_mask_unit.sv */
`timescale 1ns/1ns

module tb_mask_unit;

  import masku_pkg::*;

  localparam int NumInsn       = 24;
  // About 100 cycles per word covers slow lanes and withheld grants
  localparam int TimeoutCycles = NumInsn * WordsPerReg * 100 + 800;

  logic       clk_i = 1'b0;
  logic       rst_ni;
  mask_req_t  req_i;
  logic       req_valid_i;
  logic       req_ready_o;
  lane_beat_t operands_i = '0;
  lane_mask_t operand_valid_i = '0;
  logic       operand_ready_o;
  lane_mask_t result_req_o;
  vaddr_t     result_addr_o;
  vid_t       result_id_o;
  word_t      result_wdata_o;
  lane_mask_t result_gnt_i = '0;
  done_t      done_o;

  // Reference model state
  logic [31:0] rng = 32'h0d85_a43e;
  int          grant_level = 6;
  int          cycle_cnt = 0;
  int          done_cnt = 0;
  result_t     exp_q[$];
  mask_req_t   cur_req;
  logic        in_flight = 1'b0;
  int          nwords = 0;
  int          words_issued = 0;
  int          words_popped = 0;
  lane_mask_t  granted_mask = '0;
  done_t       done_exp = '0;
  // Outputs seen at the previous edge
  lane_mask_t  prev_req = '0;
  lane_mask_t  prev_gnt = '0;
  result_t     prev_head;
  result_t     head_now;

  mask_unit dut_i (.*);

  always #10 clk_i = ~clk_i;

  assign head_now = '{id: result_id_o, addr: result_addr_o, wdata: result_wdata_o};

  function logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function word_t rand_word();
    word_t w;
    for (int i = 0; i < WordW / 32; i++) w[i*32 +: 32] = next_rand();
    return w;
  endfunction

  // Word j of an instruction, bit k live while j*256+k < vl
  function automatic word_t expected_word(mask_op_e op, word_t a, word_t b, word_t old,
                                          int j, int vl);
    word_t res;
    word_t logic_res;
    case (op)
      MOP_AND:    logic_res = a & b;
      MOP_ANDNOT: logic_res = a & ~b;
      MOP_OR:     logic_res = a | b;
      MOP_XOR:    logic_res = a ^ b;
      MOP_NAND:   logic_res = ~(a & b);
      MOP_NOR:    logic_res = ~(a | b);
      MOP_XNOR:   logic_res = ~(a ^ b);
      default:    logic_res = a | ~b;
    endcase
    for (int k = 0; k < WordW; k++) res[k] = (j * WordW + k < vl) ? logic_res[k] : old[k];
    return res;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("sim failed");
    $fatal(1, "run stopped at %0t", $time);
  endtask

  task automatic value_mismatch(input string name, input logic [$bits(result_t)-1:0] exp,
                                input logic [$bits(result_t)-1:0] act);
    abort_run($sformatf("CHECK FAILED at %0t: %s expected %0h actual %0h",
                        $time, name, exp, act));
  endtask

  ////////////////////////////////
  // Lanes: operands and grants
  ////////////////////////////////

  always @(posedge clk_i) begin
    if (!rst_ni) begin
      operand_valid_i <= '0;
      result_gnt_i    <= '0;
      operands_i      <= '{a: rand_word(), b: rand_word(), old_vd: rand_word()};
    end else begin
      for (int l = 0; l < NrLanes; l++) begin
        // Valid drops on the ready pulse, comes back after a random delay
        if (operand_ready_o) operand_valid_i[l] <= 1'b0;
        else if (!operand_valid_i[l] && (next_rand() % 4 != 0)) operand_valid_i[l] <= 1'b1;
        // One-cycle grant pulses, never two in a row
        result_gnt_i[l] <= result_req_o[l] && !result_gnt_i[l] &&
                           (next_rand() % 8 < grant_level);
      end
      if (operand_ready_o) begin
        operands_i <= '{a: rand_word(), b: rand_word(), old_vd: rand_word()};
      end
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TimeoutCycles) begin
      abort_run($sformatf("Timeout after %0d cycles, %0d of %0d instructions done",
                          cycle_cnt, done_cnt, NumInsn));
    end
  end

  ////////////////////////////////
  // Reference model and checks
  ////////////////////////////////

  always @(posedge clk_i) begin
    lane_mask_t granted_now;
    int         queued;
    if (rst_ni) begin
      queued = exp_q.size();
      assert (req_ready_o == !in_flight)
        else value_mismatch("req_ready_o", !in_flight, req_ready_o);
      // Done pulse one edge after the last pop
      assert (done_o == done_exp) else value_mismatch("done_o", done_exp, done_o);
      if (done_exp != '0) done_cnt++;
      done_exp = '0;
      if (queued == 0) begin
        assert (result_req_o == '0) else value_mismatch("result_req_o", 0, result_req_o);
      end
      // An ungranted request holds with a stable head
      for (int l = 0; l < NrLanes; l++) begin
        if (prev_req[l] && !prev_gnt[l]) begin
          assert (result_req_o[l])
            else value_mismatch($sformatf("result_req_o[%0d]", l), 1, result_req_o[l]);
          assert (head_now == prev_head)
            else value_mismatch("result id/addr/wdata", prev_head, head_now);
        end
      end
      granted_now = result_req_o & result_gnt_i;
      if (granted_now != '0) begin
        if (queued == 0) begin
          abort_run("A lane was granted a result word that was never produced");
        end else if ((granted_now & granted_mask) != '0) begin
          abort_run("A lane was granted the same result word twice");
        end else begin
          assert (head_now == exp_q[0])
            else value_mismatch("result id/addr/wdata", exp_q[0], head_now);
          granted_mask = granted_mask | granted_now;
          if (granted_mask == '1) begin
            void'(exp_q.pop_front());
            granted_mask = '0;
            words_popped++;
            if (words_popped == nwords) begin
              in_flight                 = 1'b0;
              done_exp.done[cur_req.id] = 1'b1;
            end
          end
        end
      end
      if (operand_ready_o) begin
        assert (&operand_valid_i)
          else value_mismatch("operand_valid_i", 4'hf, operand_valid_i);
        if (queued >= ResultQueueDepth) begin
          abort_run("operand_ready_o pulsed with two result words still queued");
        end else if (!in_flight || words_issued >= nwords) begin
          abort_run("An operand beat was consumed with no word left to issue");
        end else begin
          exp_q.push_back('{id: cur_req.id,
                            addr: vaddr_t'(int'(cur_req.vd) * WordsPerReg + words_issued),
                            wdata: expected_word(cur_req.op, operands_i.a, operands_i.b,
                                                 operands_i.old_vd, words_issued,
                                                 int'(cur_req.vl))});
          words_issued++;
        end
      end
      if (req_valid_i && req_ready_o) begin
        cur_req      = req_i;
        in_flight    = 1'b1;
        words_issued = 0;
        words_popped = 0;
        nwords       = (int'(req_i.vl) + WordW - 1) / WordW;
      end
      prev_req  = result_req_o;
      prev_gnt  = result_gnt_i;
      prev_head = head_now;
    end
  end

  ////////////////////////////////
  // Sequencer
  ////////////////////////////////

  initial begin
    mask_req_t req;
    rst_ni      = 1'b0;
    req_i       = '0;
    req_valid_i = 1'b0;
    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;
    for (int i = 0; i < NumInsn; i++) begin
      @(negedge clk_i);
      // First eight walk every op at full length, then odd lengths and random ones
      req.id = vid_t'(i);
      req.op = (i < 8) ? mask_op_e'(i) : mask_op_e'(next_rand() % 8);
      req.vd = vreg_t'(next_rand());
      case (i)
        8:       req.vl = 300;
        9:       req.vl = 37;
        10:      req.vl = 1;
        11:      req.vl = 256;
        default: req.vl = (i < 8) ? vlen_t'(VlenBits) : vlen_t'(next_rand() % VlenBits + 1);
      endcase
      // Last third holds grants back so the queue fills
      grant_level = (i >= 16) ? 1 : 6;
      @(posedge clk_i);
      req_i       <= req;
      req_valid_i <= 1'b1;
      do @(negedge clk_i); while (!req_ready_o);
      @(posedge clk_i);
      req_valid_i <= 1'b0;
      while (done_cnt <= i) @(negedge clk_i);
    end
    repeat (4) @(negedge clk_i);
    if (exp_q.size() == 0 && done_cnt == NumInsn) begin
      $display("sim passed");
      $finish;
    end else begin
      abort_run("Result words or done pulses are missing at the end of the run");
    end
  end

endmodule
